/* rtl/sram_pkg.sv */
package sram_pkg;

    // byte address width on both sides of the adapter
    localparam int addr_width = 26;

    // data on the 32-bit slave side
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    // data on the half-word SRAM side
    typedef logic [15:0] half_t;
    typedef logic [1:0]  half_en_t;

    typedef logic [addr_width-1:0] addr_t;

endpackage

/* rtl/sram_bus_if.sv */
interface sram_bus_if import sram_pkg::*; ();

    // command, driven by the adapter
    addr_t    address;
    logic     read;
    logic     write;
    half_en_t byteenable;
    half_t    writedata;

    // response, driven by the controller
    half_t    readdata;
    logic     readdatavalid;
    logic     waitrequest;

    modport master (
        output address, read, write, byteenable, writedata,
        input  readdata, readdatavalid, waitrequest
    );

    modport slave (
        input  address, read, write, byteenable, writedata,
        output readdata, readdatavalid, waitrequest
    );

endinterface

/* rtl/bus_adapter.sv */
module bus_adapter import sram_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  addr_t    slave_address,
    input  logic     slave_read,
    input  logic     slave_write,
    input  byte_en_t slave_byteenable,
    input  word_t    slave_writedata,
    output word_t    slave_readdata,
    output logic     slave_readdatavalid,
    output logic     slave_waitrequest,
    sram_bus_if.master bus
);

    typedef enum logic [1:0] {
        cmd_idle,
        cmd_first,
        cmd_second
    } cmd_state_t;

    typedef enum logic {
        rx_empty,
        rx_half
    } rx_state_t;

    cmd_state_t cmd_state;
    rx_state_t  rx_state;

    // latched slave command
    addr_t    cmd_addr;
    word_t    cmd_data;
    byte_en_t cmd_be;
    logic     cmd_read;

    half_t first_half;

    logic take_cmd;
    logic issue_ok;
    logic issue_hi;
    logic issue_lo;

    // held while the controller stalls the current half
    assign issue_ok = !((bus.read || bus.write) && bus.waitrequest);

    assign take_cmd = (cmd_state == cmd_idle) && (slave_read || slave_write);
    assign issue_hi = (cmd_state == cmd_first) && issue_ok;
    assign issue_lo = (cmd_state == cmd_second) && issue_ok;

    assign slave_waitrequest = (cmd_state != cmd_idle);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cmd_state <= cmd_idle;
            bus.read  <= 1'b0;
            bus.write <= 1'b0;
        end else begin
            case (cmd_state)
                cmd_idle: begin
                    if (take_cmd) begin
                        cmd_state <= cmd_first;
                    end
                end
                cmd_first: begin
                    if (issue_hi) begin
                        cmd_state <= cmd_second;
                    end
                end
                cmd_second: begin
                    if (issue_lo) begin
                        cmd_state <= cmd_idle;
                    end
                end
                default: cmd_state <= cmd_idle;
            endcase

            if (issue_hi || issue_lo) begin
                bus.read  <= cmd_read;
                bus.write <= !cmd_read;
            end else if (!bus.waitrequest) begin
                // last half taken, bus goes quiet
                bus.read  <= 1'b0;
                bus.write <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take_cmd) begin
            cmd_addr <= {slave_address[addr_width-1:2], 2'b00};
            cmd_data <= slave_writedata;
            cmd_be   <= slave_byteenable;
            cmd_read <= slave_read;
        end

        // upper half at the word address, lower half two bytes on
        if (issue_hi) begin
            bus.address    <= cmd_addr;
            bus.byteenable <= cmd_be[3:2];
            bus.writedata  <= cmd_data[31:16];
        end else if (issue_lo) begin
            bus.address    <= cmd_addr + addr_t'(2);
            bus.byteenable <= cmd_be[1:0];
            bus.writedata  <= cmd_data[15:0];
        end
    end

    // halves come back in issue order, first one is the upper half
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rx_state <= rx_empty;
        end else if (bus.readdatavalid) begin
            rx_state <= (rx_state == rx_empty) ? rx_half : rx_empty;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.readdatavalid && (rx_state == rx_empty)) begin
            first_half <= bus.readdata;
        end
    end

    assign slave_readdata      = {first_half, bus.readdata};
    assign slave_readdatavalid = bus.readdatavalid && (rx_state == rx_half);

    a_no_read_write: assert property (
        @(posedge clock) disable iff (!reset)
        !(bus.read && bus.write)
    );

    // every word needs two half returns
    a_valid_single: assert property (
        @(posedge clock) disable iff (!reset)
        slave_readdatavalid |=> !slave_readdatavalid
    );

endmodule

/* rtl/sram_controller.sv */
module sram_controller import sram_pkg::*; #(
    parameter int READ_LATENCY = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    sram_bus_if.slave             bus,
    output logic [addr_width-2:0] mem_index,
    output logic                  mem_write,
    output half_en_t              mem_byteenable,
    output half_t                 mem_writedata,
    input  half_t                 mem_readdata
);

    // one flag per read still travelling through the array
    logic [READ_LATENCY-1:0] pending;

    logic read_accept;
    logic write_accept;

    // writes wait for the read pipeline to drain
    assign bus.waitrequest = bus.write && (|pending);

    assign read_accept  = bus.read && !bus.waitrequest;
    assign write_accept = bus.write && !bus.waitrequest;

    // byte address to half-word index
    assign mem_index      = bus.address[addr_width-1:1];
    assign mem_write      = write_accept;
    assign mem_byteenable = bus.byteenable;
    assign mem_writedata  = bus.writedata;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pending <= '0;
        end else begin
            pending[0] <= read_accept;
            for (int i = 1; i < READ_LATENCY; i++) begin
                pending[i] <= pending[i-1];
            end
        end
    end

    assign bus.readdatavalid = pending[READ_LATENCY-1];
    assign bus.readdata      = mem_readdata;

    // no write slips in while an earlier read is still in the array
    a_turnaround: assert property (
        @(posedge clock) disable iff (!reset)
        read_accept |=> !write_accept [*READ_LATENCY]
    );

endmodule

/* rtl/sram_array.sv */
module sram_array import sram_pkg::*; #(
    parameter int MEM_WORDS    = 1024,
    parameter int READ_LATENCY = 2
) (
    input  logic                  clock,
    input  logic [addr_width-2:0] mem_index,
    input  logic                  mem_write,
    input  half_en_t              mem_byteenable,
    input  half_t                 mem_writedata,
    output half_t                 mem_readdata
);

    localparam int index_width = $clog2(MEM_WORDS);

    half_t mem [MEM_WORDS];
    half_t rd_pipe [READ_LATENCY];

    logic [index_width-1:0] index;

    // indices beyond the depth wrap around
    assign index = index_width'(mem_index % MEM_WORDS);

    always_ff @(posedge clock) begin
        if (mem_write) begin
            for (int b = 0; b < 2; b++) begin
                if (mem_byteenable[b]) begin
                    mem[index][8*b +: 8] <= mem_writedata[8*b +: 8];
                end
            end
        end
    end

    // registered read plus extra output stages
    always_ff @(posedge clock) begin
        rd_pipe[0] <= mem[index];
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign mem_readdata = rd_pipe[READ_LATENCY-1];

endmodule

/* rtl/sram_subsystem.sv */
module sram_subsystem import sram_pkg::*; #(
    parameter int MEM_WORDS    = 1024,
    parameter int READ_LATENCY = 2
) (
    input  logic     clock,
    input  logic     reset,
    input  addr_t    slave_address,
    input  logic     slave_read,
    input  logic     slave_write,
    input  byte_en_t slave_byteenable,
    input  word_t    slave_writedata,
    output word_t    slave_readdata,
    output logic     slave_readdatavalid,
    output logic     slave_waitrequest
);

    sram_bus_if bus ();

    logic [addr_width-2:0] mem_index;
    logic                  mem_write;
    half_en_t              mem_byteenable;
    half_t                 mem_writedata;
    half_t                 mem_readdata;

    bus_adapter u_adapter (
        .clock               (clock),
        .reset               (reset),
        .slave_address       (slave_address),
        .slave_read          (slave_read),
        .slave_write         (slave_write),
        .slave_byteenable    (slave_byteenable),
        .slave_writedata     (slave_writedata),
        .slave_readdata      (slave_readdata),
        .slave_readdatavalid (slave_readdatavalid),
        .slave_waitrequest   (slave_waitrequest),
        .bus                 (bus.master)
    );

    sram_controller #(
        .READ_LATENCY (READ_LATENCY)
    ) u_controller (
        .clock          (clock),
        .reset          (reset),
        .bus            (bus.slave),
        .mem_index      (mem_index),
        .mem_write      (mem_write),
        .mem_byteenable (mem_byteenable),
        .mem_writedata  (mem_writedata),
        .mem_readdata   (mem_readdata)
    );

    sram_array #(
        .MEM_WORDS    (MEM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) u_array (
        .clock          (clock),
        .mem_index      (mem_index),
        .mem_write      (mem_write),
        .mem_byteenable (mem_byteenable),
        .mem_writedata  (mem_writedata),
        .mem_readdata   (mem_readdata)
    );

endmodule

/* verif/tb_tests.svh */
task automatic test_reset();
    @(posedge clock);
    check_flag("test_reset waitrequest", 1'b0, slave_waitrequest);
    check_flag("test_reset readdatavalid", 1'b0, slave_readdatavalid);
    #1;
endtask

task automatic test_word_write_read();
    addr_t address;
    address = addr_t'(random_bits(addr_width));
    write_word(address, 4'hf, random_bits(32));
    slave_address = address;
    slave_read    = 1'b1;
    wait_accept();
    #1;
    slave_read = 1'b0;
    // valid for one cycle only, read_latency+3 edges after acceptance
    for (int n = 1; n <= read_latency + 4; n++) begin
        @(posedge clock);
        check_flag("test_word_write_read valid", logic'(n == read_latency + 3),
                   slave_readdatavalid);
        if (n == read_latency + 3) begin
            check_word("test_word_write_read data", ref_word(address), slave_readdata);
        end
    end
    #1;
endtask

task automatic test_byte_enable();
    addr_t address;
    word_t known;
    word_t partial;
    word_t merged;
    word_t data;
    address = addr_t'(random_bits(addr_width));
    known   = random_bits(32);
    partial = random_bits(32);
    for (int p = 0; p < 16; p++) begin
        write_word(address, 4'hf, known);
        write_word(address, byte_en_t'(p), partial);
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = p[b] ? partial[8*b +: 8] : known[8*b +: 8];
        end
        read_word(address, data);
        check_word($sformatf("test_byte_enable be %h", p), merged, data);
    end
endtask

task automatic test_back_to_back_reads();
    addr_t addresses [8];
    word_t expected [8];
    word_t got [$];
    for (int i = 0; i < 8; i++) begin
        addresses[i] = addr_t'(random_bits(addr_width));
        write_word(addresses[i], 4'hf, random_bits(32));
    end
    // aliased addresses resolve only once every write is in
    for (int i = 0; i < 8; i++) begin
        expected[i] = ref_word(addresses[i]);
    end
    fork
        begin
            slave_read = 1'b1;
            for (int i = 0; i < 8; i++) begin
                slave_address = addresses[i];
                wait_accept();
                #1;
            end
            slave_read = 1'b0;
        end
        begin
            while (got.size() < 8) begin
                @(posedge clock);
                if (slave_readdatavalid) begin
                    got.push_back(slave_readdata);
                end
            end
        end
    join
    #1;
    for (int i = 0; i < 8; i++) begin
        check_word($sformatf("test_back_to_back_reads %0d", i), expected[i], got[i]);
    end
endtask

task automatic test_write_after_read();
    addr_t address;
    word_t old_value;
    word_t new_value;
    word_t data;
    address   = addr_t'(random_bits(addr_width));
    new_value = random_bits(32);
    write_word(address, 4'hf, random_bits(32));
    old_value = ref_word(address);
    fork
        begin
            slave_address = address;
            slave_read    = 1'b1;
            wait_accept();
            #1;
            slave_read       = 1'b0;
            slave_writedata  = new_value;
            slave_byteenable = 4'hf;
            slave_write      = 1'b1;
            wait_accept();
            #1;
            slave_write = 1'b0;
        end
        begin
            do begin
                @(posedge clock);
            end while (!slave_readdatavalid);
            data = slave_readdata;
        end
    join
    @(posedge clock);
    #1;
    check_word("test_write_after_read old", old_value, data);
    update_ref(address, 4'hf, new_value);
    read_word(address, data);
    check_word("test_write_after_read new", ref_word(address), data);
endtask

task automatic test_address_wrap();
    addr_t base;
    addr_t alias_address;
    word_t value;
    word_t data;
    for (int k = 0; k < 4; k++) begin
        // base inside the array, alias some whole array sizes above it
        base          = addr_t'(random_bits(11));
        alias_address = base + addr_t'(random_bits(8) + 1) * addr_t'(mem_words * 2);
        value         = random_bits(32);
        write_word(alias_address, 4'hf, value);
        read_word(base, data);
        check_word("test_address_wrap high to low", value, data);
        value = random_bits(32);
        write_word(base, 4'hf, value);
        read_word(alias_address, data);
        check_word("test_address_wrap low to high", value, data);
    end
endtask

/* verif/tb_sram_subsystem.sv */
module tb_sram_subsystem import sram_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_words    = 1024;
    localparam int read_latency = 2;
    localparam int clock_period = 4;
    localparam int reset_cycles = 8;

    // cycles per test: reset, word, byte enable, back to back, turnaround, wrap
    localparam int test_cycles = 2 + 16 + 16 * 12 + 56 + 24 + 4 * 18;
    localparam int limit_ns    = ((reset_cycles + test_cycles) * 4 + 100) * clock_period;

    logic     clock;
    logic     reset;
    addr_t    slave_address;
    logic     slave_read;
    logic     slave_write;
    byte_en_t slave_byteenable;
    word_t    slave_writedata;
    word_t    slave_readdata;
    logic     slave_readdatavalid;
    logic     slave_waitrequest;

    int checks;
    int errors;
    logic [31:0] lfsr;

    // expected contents, one entry per half-word
    half_t ref_mem [mem_words];

    sram_subsystem #(
        .MEM_WORDS    (mem_words),
        .READ_LATENCY (read_latency)
    ) DUT (
        .clock               (clock),
        .reset               (reset),
        .slave_address       (slave_address),
        .slave_read          (slave_read),
        .slave_write         (slave_write),
        .slave_byteenable    (slave_byteenable),
        .slave_writedata     (slave_writedata),
        .slave_readdata      (slave_readdata),
        .slave_readdatavalid (slave_readdatavalid),
        .slave_waitrequest   (slave_waitrequest)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < count; i++) begin
            bit_out = lfsr[0];
            lfsr = lfsr >> 1;
            if (bit_out) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            value = {value[30:0], bit_out};
        end
        return value;
    endfunction

    // low two address bits carry no meaning
    function automatic addr_t word_base(addr_t address);
        return {address[addr_width-1:2], 2'b00};
    endfunction

    function automatic int half_index(addr_t address);
        return int'(address >> 1) % mem_words;
    endfunction

    function automatic void update_ref(addr_t address, byte_en_t be, word_t data);
        int hi;
        int lo;
        hi = half_index(word_base(address));
        lo = half_index(word_base(address) + addr_t'(2));
        for (int b = 0; b < 2; b++) begin
            if (be[b + 2]) begin
                ref_mem[hi][8*b +: 8] = data[16 + 8*b +: 8];
            end
            if (be[b]) begin
                ref_mem[lo][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // upper half at the word address, lower half two bytes on
    function automatic word_t ref_word(addr_t address);
        return {ref_mem[half_index(word_base(address))],
                ref_mem[half_index(word_base(address) + addr_t'(2))]};
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // command stays on the inputs until an edge with waitrequest low
    task automatic wait_accept();
        do begin
            @(posedge clock);
        end while (slave_waitrequest);
    endtask

    task automatic write_word(addr_t address, byte_en_t be, word_t data);
        slave_address    = address;
        slave_byteenable = be;
        slave_writedata  = data;
        slave_write      = 1'b1;
        wait_accept();
        #1;
        slave_write = 1'b0;
        update_ref(address, be, data);
    endtask

    task automatic read_word(addr_t address, output word_t data);
        slave_address = address;
        slave_read    = 1'b1;
        wait_accept();
        #1;
        slave_read = 1'b0;
        do begin
            @(posedge clock);
        end while (!slave_readdatavalid);
        data = slave_readdata;
        #1;
    endtask

    `include "tb_tests.svh"

    initial begin
        reset            = 1'b0;
        slave_address    = '0;
        slave_read       = 1'b0;
        slave_write      = 1'b0;
        slave_byteenable = '0;
        slave_writedata  = '0;
        checks           = 0;
        errors           = 0;
        lfsr             = 32'he051_5015;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b1;

        test_reset();
        test_word_write_read();
        test_byte_enable();
        test_back_to_back_reads();
        test_write_after_read();
        test_address_wrap();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(limit_ns);
        $display("timeout: the tests did not finish within %0d ns", limit_ns);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* src.f */
+incdir+verif
rtl/sram_pkg.sv
rtl/sram_bus_if.sv
rtl/bus_adapter.sv
rtl/sram_controller.sv
rtl/sram_array.sv
rtl/sram_subsystem.sv
verif/tb_sram_subsystem.sv
